// File: color_engine.f
+incdir+source
source/color_pkg.sv
source/color_fifo.sv
source/color_dispatch.sv
source/color_lane.sv
source/color_collect.sv
source/color_regs.sv
source/color_engine.sv
dv/color_engine_asserts.sv
dv/color_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the testbench, status follows the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f color_engine.f \
   --top-module color_engine_tb -o color_engine_tb_sim || exit 1

out=$(./obj_dir/color_engine_tb_sim)
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1

// File: dv/color_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "color_settings.svh"

module color_engine_tb import color_pkg::*; ();
   localparam int max_cycles = 16 + 127 * 20 + 10 * 3;

   logic clk, rstn, task_valid, task_ready, result_valid, result_ready;
   logic psel, penable, pwrite, pready, pslverr;
   logic [`COLOR_APB_AW-1:0] paddr;
   logic [31:0]   pwdata, prdata, lfsr;
   color_task_t   task_data;
   color_result_t result_data;
   color_result_t got_q [$];
   int errors, tests, n_sent, n_bad, n_res, cycles, stall_mode;
   logic [`COLOR_COLOR_W-1:0] exp_color [64];
   bit exp_on [64];

   color_engine u_color_engine (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;   // galois taps
      return b;
   endfunction

   function automatic int rand_below(int n);
      int v;
      v = 0;
      for (int i = 0; i < 8; i++) v = (v << 1) | int'(lfsr_bit());
      return v % n;
   endfunction

   function automatic color_task_t mk(task_kind_t k, logic [`COLOR_VID_W-1:0] v,
         logic [`COLOR_VID_W-1:0] n, logic [`COLOR_DEG_W-1:0] d, logic [`COLOR_COLOR_W-1:0] c);
      color_task_t t;
      t.kind  = k;
      t.vid   = v;
      t.nid   = n;
      t.deg   = d;
      t.color = c;
      return t;
   endfunction

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > max_cycles) begin
         $display("timeout after %0d cycles", cycles);
         $display("Something failed");
         $finish;
      end else begin
         if (rstn && result_valid && result_ready) begin
            got_q.push_back(result_data);
            n_res <= n_res + 1;
         end
         case (stall_mode)
            0:       result_ready <= 1'b1;
            1:       result_ready <= 1'b0;
            default: result_ready <= lfsr_bit();
         endcase
      end
   end

   task automatic check_result(color_result_t exp, color_result_t got);
      if (exp !== got) begin
         $display("ERROR %0t result_data exp vid %0d color %0d got vid %0d color %0d",
                  $time, exp.vid, exp.color, got.vid, got.color);
         errors++;
      end
   endtask

   task automatic check_reg(string name, logic [31:0] exp, logic [31:0] got);
      if (exp !== got) begin
         $display("ERROR %0t %s exp %0d got %0d", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic check_flag(string name, logic exp, logic got);
      if (exp !== got) begin
         $display("ERROR %0t %s exp %b got %b", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic apb_write(logic [`COLOR_APB_AW-1:0] a, logic [31:0] d);
      @(posedge clk);
      psel   <= 1'b1;
      pwrite <= 1'b1;
      paddr  <= a;
      pwdata <= d;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      check_flag("pready", 1'b1, pready);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(logic [`COLOR_APB_AW-1:0] a, output logic [31:0] d,
                           output logic err);
      @(posedge clk);
      psel   <= 1'b1;
      pwrite <= 1'b0;
      paddr  <= a;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      d = prdata;
      err = pslverr;
      check_flag("pready", 1'b1, pready);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic send_task(color_task_t t);
      @(posedge clk);
      task_valid <= 1'b1;
      task_data  <= t;
      do @(posedge clk); while (!task_ready);
      task_valid <= 1'b0;
      if (t.kind inside {set_degree, receive_degree, receive_color}) n_sent++;
      else n_bad++;
   endtask

   // waits for n results, then a short tail to catch extras
   task automatic expect_results(int n);
      color_result_t e;
      while (got_q.size() < n) @(posedge clk);
      repeat (8) @(posedge clk);
      foreach (got_q[i]) begin
         if (!exp_on[got_q[i].vid]) begin
            $display("unexpected or repeated result for vertex %0d", got_q[i].vid);
            errors++;
         end else begin
            e.vid = got_q[i].vid;
            e.color = exp_color[got_q[i].vid];
            check_result(e, got_q[i]);
            exp_on[got_q[i].vid] = 1'b0;
         end
      end
      got_q.delete();
      foreach (exp_on[i]) exp_on[i] = 1'b0;
   endtask

   task automatic finish_test(string name, int e0);
      tests++;
      $display("test %s: %s", name, (errors == e0) ? "ok" : "errors");
   endtask

   task automatic test_regs();
      int e0;
      logic [31:0] d;
      logic err;
      e0 = errors;
      apb_read(`COLOR_REG_CTRL, d, err);
      check_reg("ctrl", 0, d);
      apb_read(`COLOR_REG_TASKS, d, err);
      check_reg("tasks", 0, d);
      apb_read(`COLOR_REG_DONE, d, err);
      check_reg("done", 0, d);
      apb_read(`COLOR_REG_BAD, d, err);
      check_reg("bad", 0, d);
      @(posedge clk);
      task_valid <= 1'b1;
      task_data  <= mk(set_degree, 6'd1, 6'd0, 8'd0, 6'd0);
      repeat (4) begin
         @(posedge clk);
         if (task_ready) begin
            $display("task_ready went high while the engine was disabled");
            errors++;
         end
      end
      apb_write(`COLOR_REG_CTRL, 32'd1);
      do @(posedge clk); while (!task_ready);
      task_valid <= 1'b0;
      n_sent++;
      apb_read(`COLOR_REG_CTRL, d, err);
      check_reg("ctrl", 1, d);
      apb_read(8'h10, d, err);
      check_flag("pslverr", 1'b1, err);
      exp_on[1] = 1'b1;
      exp_color[1] = '0;
      expect_results(1);
      finish_test("registers", e0);
   endtask

   task automatic test_isolated();
      int e0, j, tmp;
      int v [8] = '{2, 3, 5, 6, 13, 20, 31, 45};
      e0 = errors;
      for (int i = 7; i > 0; i--) begin   // shuffle the send order
         j = rand_below(i + 1);
         tmp = v[i];
         v[i] = v[j];
         v[j] = tmp;
      end
      foreach (v[i]) begin
         send_task(mk(set_degree, 6'(v[i]), 6'd0, 8'd0, 6'd0));
         exp_on[v[i]] = 1'b1;
         exp_color[v[i]] = '0;
      end
      expect_results(8);
      finish_test("isolated", e0);
   endtask

   task automatic test_graph();
      int e0, p, k, c;
      int deg [4] = '{2, 2, 3, 1};
      int eu [4] = '{0, 0, 1, 2};
      int ev [4] = '{1, 2, 2, 3};
      int ref_c [4] = '{-1, -1, -1, -1};
      logic [`COLOR_MAP_W:0] used;
      bit rdy;
      color_result_t r;
      e0 = errors;
      // greedy by rank, a neighbor outranks on higher degree or equal degree and lower id
      repeat (4) for (int v = 0; v < 4; v++) begin
         used = '0;
         rdy = (ref_c[v] < 0);
         for (int e = 0; e < 4; e++) begin
            k = (eu[e] == v) ? ev[e] : (ev[e] == v) ? eu[e] : -1;
            if (k >= 0 && (deg[k] > deg[v] || (deg[k] == deg[v] && k < v))) begin
               if (ref_c[k] < 0) rdy = 0;
               else used[ref_c[k]] = 1'b1;
            end
         end
         if (rdy) begin
            c = 0;
            while (used[c]) c++;
            ref_c[v] = c;
         end
      end
      for (int v = 0; v < 4; v++) begin
         send_task(mk(set_degree, 6'(40 + v), 6'd0, 8'(deg[v]), 6'd0));
         exp_on[40 + v] = 1'b1;
         exp_color[40 + v] = 6'(ref_c[v]);
      end
      for (int e = 0; e < 4; e++) begin
         send_task(mk(receive_degree, 6'(40 + eu[e]), 6'(40 + ev[e]), 8'(deg[ev[e]]), 6'd0));
         send_task(mk(receive_degree, 6'(40 + ev[e]), 6'(40 + eu[e]), 8'(deg[eu[e]]), 6'd0));
      end
      p = 0;
      while (p < 4) begin   // fan each color out to the neighbors
         while (got_q.size() <= p) @(posedge clk);
         r = got_q[p];
         p++;
         k = int'(r.vid) - 40;
         for (int e = 0; e < 4; e++) begin
            if (eu[e] == k)
               send_task(mk(receive_color, 6'(40 + ev[e]), r.vid, 8'(deg[k]), r.color));
            if (ev[e] == k)
               send_task(mk(receive_color, 6'(40 + eu[e]), r.vid, 8'(deg[k]), r.color));
         end
      end
      expect_results(4);
      finish_test("graph", e0);
   endtask

   task automatic test_color_choice();
      int e0;
      int cols [3] = '{0, 1, 3};
      e0 = errors;
      send_task(mk(set_degree, 6'd4, 6'd0, 8'd3, 6'd0));
      for (int i = 0; i < 3; i++) send_task(mk(receive_degree, 6'd4, 6'(9 + i), 8'd5, 6'd0));
      for (int i = 0; i < 3; i++)
         send_task(mk(receive_color, 6'd4, 6'(9 + i), 8'd5, 6'(cols[i])));
      exp_on[4] = 1'b1;
      exp_color[4] = 6'd2;
      expect_results(1);
      send_task(mk(set_degree, 6'd8, 6'd0, 8'd32, 6'd0));
      for (int i = 0; i < 32; i++) send_task(mk(receive_degree, 6'd8, 6'(i), 8'd40, 6'd0));
      for (int i = 0; i < 32; i++) send_task(mk(receive_color, 6'd8, 6'(i), 8'd40, 6'(i)));
      exp_on[8] = 1'b1;
      exp_color[8] = 6'd32;
      expect_results(1);
      finish_test("color_choice", e0);
   endtask

   task automatic test_backpressure();
      int e0, k, x, n_exp;
      bit dropped;
      logic [31:0] d;
      logic err;
      e0 = errors;
      dropped = 0;
      n_exp = 16;
      stall_mode <= 1;
      for (k = 0; k < 16 && !dropped; k++) begin   // lane 0 only
         @(posedge clk);
         task_data <= mk(set_degree, 6'(4 * k), 6'd0, 8'd0, 6'd0);
         @(posedge clk);
         @(posedge clk);
         if (!task_ready) dropped = 1;
         else send_task(mk(set_degree, 6'(4 * k), 6'd0, 8'd0, 6'd0));
      end
      if (!dropped) begin
         $display("task_ready never dropped under back-pressure");
         errors++;
      end
      stall_mode <= 2;
      for (k = k - 1; k < 16; k++) begin
         send_task(mk(set_degree, 6'(4 * k), 6'd0, 8'd0, 6'd0));
         x = 4 * k + 1 + k % 3;   // other lanes compete for the collector
         send_task(mk(set_degree, 6'(x), 6'd0, 8'd0, 6'd0));
         exp_on[x] = 1'b1;
         exp_color[x] = '0;
         n_exp++;
      end
      send_task(mk(task_kind_t'(2'b11), 6'd7, 6'd0, 8'd0, 6'd0));
      send_task(mk(task_kind_t'(2'b11), 6'd60, 6'd1, 8'd1, 6'd0));
      for (int i = 0; i < 16; i++) begin
         exp_on[4 * i] = 1'b1;
         exp_color[4 * i] = '0;
      end
      expect_results(n_exp);
      stall_mode <= 0;
      apb_read(`COLOR_REG_TASKS, d, err);
      check_reg("tasks", n_sent, d);
      check_flag("pslverr", 1'b0, err);
      apb_read(`COLOR_REG_DONE, d, err);
      check_reg("done", n_res, d);
      check_flag("pslverr", 1'b0, err);
      apb_read(`COLOR_REG_BAD, d, err);
      check_reg("bad", n_bad, d);
      check_flag("pslverr", 1'b0, err);
      finish_test("backpressure", e0);
   endtask

   initial begin
      lfsr = 32'h4d02;
      rstn = 1'b0;
      task_valid = 1'b0;
      task_data = '0;
      result_ready = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      errors = 0;
      tests = 0;
      n_sent = 0;
      n_bad = 0;
      n_res = 0;
      cycles = 0;
      stall_mode = 0;
      foreach (exp_on[i]) exp_on[i] = 1'b0;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      test_regs();
      test_isolated();
      test_graph();
      test_color_choice();
      test_backpressure();
      $display("tests %0d, results %0d, errors %0d", tests, n_res, errors);
      if (errors == 0) $display("Everything OK");
      else $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/color_engine_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module color_engine_asserts import color_pkg::*; (
   input wire logic          clk,
   input wire logic          rstn,
   input wire logic          task_valid,
   input wire logic          task_ready,
   input wire color_task_t   task_data,
   input wire logic          result_valid,
   input wire logic          result_ready,
   input wire color_result_t result_data,
   input wire logic          psel,
   input wire logic          penable,
   input wire logic          pslverr
);

   a_task_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_valid && !task_ready |=> $stable(task_data))
      else $error("task_data changed while stalled");

   a_result_hold: assert property (@(posedge clk) disable iff (!rstn)
      result_valid && !result_ready |=> $stable(result_data))
      else $error("result_data changed while stalled");

   // access phase follows its setup cycle
   a_slverr_access: assert property (@(posedge clk) disable iff (!rstn)
      pslverr |-> psel && penable && $past(psel && !penable))
      else $error("pslverr outside access phase");

   // state is settled one edge into reset
   a_reset_quiet: assert property (@(posedge clk)
      (!rstn ##1 !rstn) |-> !result_valid && !task_ready)
      else $error("handshake active during reset");

endmodule

bind color_engine color_engine_asserts u_asserts (.*);

`default_nettype wire

// File: source/color_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "color_settings.svh"

module color_engine import color_pkg::*; (
   input  wire logic                     clk,
   input  wire logic                     rstn,
   input  wire logic                     task_valid,
   output logic                          task_ready,
   input  wire color_task_t              task_data,
   output logic                          result_valid,
   input  wire logic                     result_ready,
   output color_result_t                 result_data,
   input  wire logic                     psel,
   input  wire logic                     penable,
   input  wire logic                     pwrite,
   input  wire logic [`COLOR_APB_AW-1:0] paddr,
   input  wire logic [31:0]              pwdata,
   output logic [31:0]                   prdata,
   output logic                          pready,
   output logic                          pslverr
);
   logic [`COLOR_NUM_LANES-1:0]          lane_task_valid;
   logic [`COLOR_NUM_LANES-1:0]          lane_task_ready;
   color_task_t                          lane_task_data;
   logic [`COLOR_NUM_LANES-1:0]          lane_res_valid;
   logic [`COLOR_NUM_LANES-1:0]          lane_res_ready;
   color_result_t [`COLOR_NUM_LANES-1:0] lane_res_data;
   logic                                 task_accepted;
   logic                                 task_rejected;
   logic                                 result_sent;
   logic                                 enable;

   color_dispatch u_dispatch (
      .enable          (enable),
      .task_valid      (task_valid),
      .task_ready      (task_ready),
      .task_data       (task_data),
      .lane_task_valid (lane_task_valid),
      .lane_task_ready (lane_task_ready),
      .lane_task_data  (lane_task_data),
      .task_accepted   (task_accepted),
      .task_rejected   (task_rejected)
   );

   for (genvar g = 0; g < `COLOR_NUM_LANES; g++) begin : g_lane
      color_lane u_lane (
         .clk       (clk),
         .rstn      (rstn),
         .in_valid  (lane_task_valid[g]),
         .in_ready  (lane_task_ready[g]),
         .in_data   (lane_task_data),
         .res_valid (lane_res_valid[g]),
         .res_ready (lane_res_ready[g]),
         .res_data  (lane_res_data[g])
      );
   end

   color_collect u_collect (
      .clk            (clk),
      .rstn           (rstn),
      .lane_res_valid (lane_res_valid),
      .lane_res_ready (lane_res_ready),
      .lane_res_data  (lane_res_data),
      .result_valid   (result_valid),
      .result_ready   (result_ready),
      .result_data    (result_data),
      .result_sent    (result_sent)
   );

   color_regs u_regs (
      .clk           (clk),
      .rstn          (rstn),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .task_accepted (task_accepted),
      .task_rejected (task_rejected),
      .result_sent   (result_sent),
      .enable        (enable)
   );

endmodule

`default_nettype wire

// File: source/color_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "color_settings.svh"

module color_regs (
   input  wire logic                     clk,
   input  wire logic                     rstn,
   input  wire logic                     psel,
   input  wire logic                     penable,
   input  wire logic                     pwrite,
   input  wire logic [`COLOR_APB_AW-1:0] paddr,
   input  wire logic [31:0]              pwdata,
   output logic [31:0]                   prdata,
   output logic                          pready,
   output logic                          pslverr,
   input  wire logic                     task_accepted,
   input  wire logic                     task_rejected,
   input  wire logic                     result_sent,
   output logic                          enable
);
   logic [31:0] task_cnt;
   logic [31:0] done_cnt;
   logic [31:0] bad_cnt;
   logic        addr_hit;
   logic        wr_ctrl;
   logic        clr;

   assign addr_hit = paddr inside {`COLOR_REG_CTRL, `COLOR_REG_TASKS,
                                   `COLOR_REG_DONE, `COLOR_REG_BAD};
   assign pready   = 1'b1;   // no wait states
   assign pslverr  = psel && penable && !addr_hit;

   assign wr_ctrl = psel && penable && pwrite && (paddr == `COLOR_REG_CTRL);
   assign clr     = wr_ctrl && pwdata[1];   // bit 1 self clears

   always_comb begin
      case (paddr)
         `COLOR_REG_CTRL:  prdata = {31'b0, enable};
         `COLOR_REG_TASKS: prdata = task_cnt;
         `COLOR_REG_DONE:  prdata = done_cnt;
         `COLOR_REG_BAD:   prdata = bad_cnt;
         default:          prdata = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         enable <= 1'b0;
      end else if (wr_ctrl) begin
         enable <= pwdata[0];
      end
   end

   // counters saturate never, they just wrap
   always_ff @(posedge clk) begin
      if (!rstn || clr) begin
         task_cnt <= '0;
         done_cnt <= '0;
         bad_cnt  <= '0;
      end else begin
         if (task_accepted) task_cnt <= task_cnt + 1'b1;
         if (result_sent)   done_cnt <= done_cnt + 1'b1;
         if (task_rejected) bad_cnt  <= bad_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/color_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "color_settings.svh"

module color_collect import color_pkg::*; (
   input  wire logic                                 clk,
   input  wire logic                                 rstn,
   input  wire logic [`COLOR_NUM_LANES-1:0]          lane_res_valid,
   output logic [`COLOR_NUM_LANES-1:0]               lane_res_ready,
   input  wire color_result_t [`COLOR_NUM_LANES-1:0] lane_res_data,
   output logic                                      result_valid,
   input  wire logic                                 result_ready,
   output color_result_t                             result_data,
   output logic                                      result_sent
);
   logic [`COLOR_LANE_BITS-1:0] ptr;
   logic [`COLOR_LANE_BITS-1:0] gnt;
   logic                        found;

   // first valid lane at or after ptr
   always_comb begin
      logic [`COLOR_LANE_BITS-1:0] cand;
      gnt   = ptr;
      found = 1'b0;
      for (int i = 0; i < `COLOR_NUM_LANES; i++) begin
         cand = ptr + `COLOR_LANE_BITS'(i);   // wraps, lane count is 2**n
         if (!found && lane_res_valid[cand]) begin
            gnt   = cand;
            found = 1'b1;
         end
      end
   end

   assign result_valid = found;
   assign result_data  = lane_res_data[gnt];
   assign result_sent  = result_valid && result_ready;

   always_comb begin
      lane_res_ready = '0;
      if (found) lane_res_ready[gnt] = result_ready;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ptr <= '0;
      end else if (result_sent) begin
         ptr <= gnt + 1'b1;   // skip past the winner
      end else if (found) begin
         ptr <= gnt;   // park on a stalled grant
      end
   end

endmodule

`default_nettype wire

// File: source/color_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "color_settings.svh"

module color_lane import color_pkg::*; (
   input  wire logic          clk,
   input  wire logic          rstn,
   input  wire logic          in_valid,
   output logic               in_ready,
   input  wire color_task_t   in_data,
   output logic               res_valid,
   input  wire logic          res_ready,
   output color_result_t      res_data
);
   localparam int idx_w = `COLOR_VID_W - `COLOR_LANE_BITS;

   color_task_t               hd;
   logic                      hd_valid;
   logic                      push_ready;
   logic                      apply;
   logic                      outranks;
   logic                      finish;
   logic [idx_w-1:0]          idx;
   vertex_rec_t               recs [`COLOR_LANE_DEPTH];
   vertex_rec_t               rec;
   vertex_rec_t               upd;
   vertex_rec_t               wr;
   logic [`COLOR_COLOR_W-1:0] pick;
   color_result_t             res_in;

   // lowest free color, 32 when every bit is taken
   function automatic logic [`COLOR_COLOR_W-1:0] lowest_clear(
      input logic [`COLOR_MAP_W-1:0] map
   );
      logic [`COLOR_COLOR_W-1:0] c;
      c = `COLOR_COLOR_W'(`COLOR_MAP_W);
      for (int i = `COLOR_MAP_W - 1; i >= 0; i--) begin
         if (!map[i]) c = `COLOR_COLOR_W'(i);
      end
      return c;
   endfunction

   color_fifo #(
      .payload_t (color_task_t),
      .depth     (`COLOR_FIFO_DEPTH)
   ) u_task_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (hd_valid),
      .out_ready (apply),
      .out_data  (hd)
   );

   assign idx   = hd.vid[`COLOR_VID_W-1:`COLOR_LANE_BITS];
   assign rec   = recs[idx];
   assign apply = hd_valid && push_ready;   // hold head while results are full

   // higher degree wins, lower id breaks a tie
   assign outranks = (hd.deg > rec.degree) ||
                     ((hd.deg == rec.degree) && (hd.nid < hd.vid));

   always_comb begin
      upd = rec;
      case (hd.kind)
         set_degree: begin
            upd          = '0;
            upd.degree   = hd.deg;
            upd.pend_deg = hd.deg;
         end
         receive_degree: begin
            upd.pend_deg = rec.pend_deg - 1'b1;
            if (outranks) upd.pend_col = rec.pend_col + 1'b1;
         end
         receive_color: begin
            if (outranks) begin
               upd.pend_col = rec.pend_col - 1'b1;
               upd.bitmap   = rec.bitmap | (`COLOR_MAP_W'(1) << hd.color);
            end
         end
         default: ;
      endcase
   end

   assign finish = apply && (upd.pend_deg == '0) && (upd.pend_col == '0) && !upd.colored;
   assign pick   = lowest_clear(upd.bitmap);

   always_comb begin
      wr = upd;
      if (finish) wr.colored = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `COLOR_LANE_DEPTH; i++) recs[i] <= '0;
      end else if (apply) begin
         recs[idx] <= wr;
      end
   end

   assign res_in.vid   = hd.vid;
   assign res_in.color = pick;

   color_fifo #(
      .payload_t (color_result_t),
      .depth     (`COLOR_FIFO_DEPTH)
   ) u_res_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (finish),
      .in_ready  (push_ready),
      .in_data   (res_in),
      .out_valid (res_valid),
      .out_ready (res_ready),
      .out_data  (res_data)
   );

endmodule

`default_nettype wire

// File: source/color_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "color_settings.svh"

module color_dispatch import color_pkg::*; (
   input  wire logic                        enable,
   input  wire logic                        task_valid,
   output logic                             task_ready,
   input  wire color_task_t                 task_data,
   output logic [`COLOR_NUM_LANES-1:0]      lane_task_valid,
   input  wire logic [`COLOR_NUM_LANES-1:0] lane_task_ready,
   output color_task_t                      lane_task_data,
   output logic                             task_accepted,
   output logic                             task_rejected
);
   localparam int idx_w = `COLOR_VID_W - `COLOR_LANE_BITS;

   logic [`COLOR_LANE_BITS-1:0] lane_sel;
   logic [idx_w-1:0]            rec_idx;
   logic                        kind_ok;
   logic                        bad;

   assign lane_sel = task_data.vid[`COLOR_LANE_BITS-1:0];  // low bits pick the lane
   assign rec_idx  = task_data.vid[`COLOR_VID_W-1:`COLOR_LANE_BITS];
   assign kind_ok  = task_data.kind inside {set_degree, receive_degree, receive_color};
   assign bad      = !kind_ok || (int'(rec_idx) >= `COLOR_LANE_DEPTH);

   // bad tasks are swallowed right away
   assign task_ready     = enable && (bad || lane_task_ready[lane_sel]);
   assign lane_task_data = task_data;

   always_comb begin
      lane_task_valid = '0;
      if (enable && task_valid && !bad) begin
         lane_task_valid[lane_sel] = 1'b1;
      end
   end

   assign task_accepted = task_valid && task_ready && !bad;
   assign task_rejected = task_valid && task_ready && bad;

endmodule

`default_nettype wire

// File: source/color_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module color_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 4
) (
   input  wire logic     clk,
   input  wire logic     rstn,
   input  wire logic     in_valid,
   output logic          in_ready,
   input  wire payload_t in_data,
   output logic          out_valid,
   input  wire logic     out_ready,
   output payload_t      out_data
);
   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;
   logic             pop;

   assign in_ready  = (count != cnt_w'(depth));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)  rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)      count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/color_pkg.sv
`default_nettype none

`include "color_settings.svh"

package color_pkg;

   // code 2'b11 is not a task
   typedef enum logic [1:0] {
      set_degree     = 2'd0,
      receive_degree = 2'd1,
      receive_color  = 2'd2
   } task_kind_t;

   // 28 bits
   typedef struct packed {
      task_kind_t                kind;
      logic [`COLOR_VID_W-1:0]   vid;    // locale
      logic [`COLOR_VID_W-1:0]   nid;    // sending neighbor
      logic [`COLOR_DEG_W-1:0]   deg;    // own degree on set_degree
      logic [`COLOR_COLOR_W-1:0] color;
   } color_task_t;

   // 12 bits
   typedef struct packed {
      logic [`COLOR_VID_W-1:0]   vid;
      logic [`COLOR_COLOR_W-1:0] color;
   } color_result_t;

   // 57 bits, one per vertex
   typedef struct packed {
      logic [`COLOR_DEG_W-1:0] degree;
      logic [`COLOR_DEG_W-1:0] pend_deg;  // neighbor degrees still to come
      logic [`COLOR_DEG_W-1:0] pend_col;  // outranking colors still to come
      logic [`COLOR_MAP_W-1:0] bitmap;    // colors taken by neighbors
      logic                    colored;
   } vertex_rec_t;

endpackage

`default_nettype wire

// File: source/color_settings.svh
`ifndef COLOR_SETTINGS_SVH
`define COLOR_SETTINGS_SVH

// lane count must stay a power of two
`define COLOR_NUM_LANES   4
`define COLOR_LANE_BITS   2
`define COLOR_LANE_DEPTH  16

`define COLOR_VID_W       6
`define COLOR_DEG_W       8
`define COLOR_COLOR_W     6   // 0..32
`define COLOR_MAP_W       32
`define COLOR_FIFO_DEPTH  4

`define COLOR_APB_AW      8
`define COLOR_REG_CTRL    'h0
`define COLOR_REG_TASKS   'h4
`define COLOR_REG_DONE    'h8
`define COLOR_REG_BAD     'hC

`endif
